// File: verilog/ic_cfg.svh
`ifndef IC_CFG_SVH
`define IC_CFG_SVH

// virtual and physical addresses share one width
`define IC_VA_W 32

// bits below the page number
`define IC_PAGE_W 10

// direct-mapped cache, one word per line
`define IC_INDEX_W 6

// translation buffer slots come from the low page bits
`define IC_TLB_W 3

// top four physical page bits that mark I/O space
`define IC_IO_PAGE 4'hF

`endif

// File: verilog/ic_pkg.sv
`include "ic_cfg.svh"

package ic_pkg;

	typedef logic [`IC_VA_W-1:0] ic_addr_t;
	typedef logic [31:0] ic_word_t;

	// page numbers sit above the page offset
	typedef logic [`IC_VA_W-`IC_PAGE_W-1:0] ic_vpn_t;
	typedef logic [`IC_VA_W-`IC_PAGE_W-1:0] ic_ppn_t;

	// everything above index and byte bits
	typedef logic [`IC_VA_W-`IC_INDEX_W-3:0] ic_tag_t;

	typedef struct packed {
		logic     read;
		ic_addr_t va;
		logic     user;
	} ic_fetch_t;

	typedef struct packed {
		ic_vpn_t vpn;
		ic_ppn_t ppn;
		logic    sup;
	} ic_tlb_ent_t;

endpackage

// File: verilog/icache_sm.sv
`timescale 1ns/1ns

module icache_sm
(
	input  logic BCLK,
	input  logic BRESET,
	input  logic read,
	input  logic io_space,
	input  logic mdone,
	input  logic io_ready,
	input  logic mmu_hit,
	input  logic ca_hit,
	input  logic prot_error,
	input  logic ptb_wr,
	input  logic ptb_sel,
	output logic dram_acc,
	output logic io_rd,
	output logic acc_ok,
	output logic cupdate,
	output logic aux_dat,
	output logic new_ptb,
	output logic ptb_one
);

	logic [2:0] next_act;
	logic       io_acc;
	logic       dram_go;
	logic       do_ca_rd;
	logic       rd_ende;
	logic       io_busy;
	logic       fill_pend;
	logic       rd_rdy;
	logic       io_done;

	assign rd_ende = ca_hit | rd_rdy;
	assign io_busy = io_rd | io_done;

	// read, prot, io space, io busy, tlb hit, read end, dram busy
	always_comb
	begin
		casez ({read, prot_error, io_space, io_busy, mmu_hit, rd_ende, dram_acc})
			7'b1010_1?0: next_act = 3'b001;
			7'b1000_100: next_act = 3'b110;
			default:     next_act = 3'b000;
		endcase
	end

	assign io_acc   = next_act[0];
	assign dram_go  = next_act[1];
	assign do_ca_rd = next_act[2];

	// a fill stays pending until the DRAM answers
	always_ff @(posedge BCLK or negedge BRESET)
	begin
		if (!BRESET)
		begin
			fill_pend <= 1'b0;
			rd_rdy    <= 1'b0;
			dram_acc  <= 1'b0;
		end
		else
		begin
			fill_pend <= do_ca_rd | (fill_pend & ~mdone);
			rd_rdy    <= fill_pend & mdone;
			dram_acc  <= dram_go | (dram_acc & ~mdone);
		end
	end

	assign cupdate = fill_pend & mdone;
	assign aux_dat = rd_rdy;

	always_ff @(posedge BCLK or negedge BRESET)
	begin
		if (!BRESET)
		begin
			io_rd   <= 1'b0;
			io_done <= 1'b0;
		end
		else
		begin
			io_rd   <= io_acc | (io_rd & ~io_ready);
			io_done <= io_rd & io_ready;
		end
	end

	assign acc_ok = ~prot_error & (io_space ? io_done : (read & mmu_hit & rd_ende));

	always_ff @(posedge BCLK or negedge BRESET)
	begin
		if (!BRESET)
		begin
			new_ptb <= 1'b0;
			ptb_one <= 1'b0;
		end
		else
		begin
			new_ptb <= ptb_wr;
			if (ptb_wr)
				ptb_one <= ptb_sel;
		end
	end

endmodule

// File: verilog/ic_tag_ram.sv
`timescale 1ns/1ns

`include "ic_cfg.svh"

module ic_tag_ram
(
	input  logic             BCLK,
	input  logic             BRESET,
	input  ic_pkg::ic_addr_t paddr,
	input  logic             cupdate,
	input  logic             flush_all,
	output logic             ca_hit
);

	localparam int LINES = 1 << `IC_INDEX_W;

	ic_pkg::ic_tag_t          tags [0:LINES-1];
	logic [LINES-1:0]         valid;
	logic [`IC_INDEX_W-1:0]   idx;
	ic_pkg::ic_tag_t          tag_in;

	// byte bits are dropped, one word per line
	assign idx    = paddr[`IC_INDEX_W+1:2];
	assign tag_in = paddr[`IC_VA_W-1:`IC_INDEX_W+2];

	always_ff @(posedge BCLK or negedge BRESET)
	begin
		if (!BRESET)
			valid <= '0;
		else if (flush_all)
			valid <= '0;
		else if (cupdate)
			valid[idx] <= 1'b1;
	end

	always_ff @(posedge BCLK)
	begin
		if (cupdate)
			tags[idx] <= tag_in;
	end

	assign ca_hit = valid[idx] & (tags[idx] == tag_in);

endmodule

// File: verilog/ic_data_ram.sv
`timescale 1ns/1ns

`include "ic_cfg.svh"

module ic_data_ram
(
	input  logic             BCLK,
	input  ic_pkg::ic_addr_t paddr,
	input  logic             cupdate,
	input  logic             aux_dat,
	input  ic_pkg::ic_word_t mdata,
	input  ic_pkg::ic_word_t io_data,
	input  logic             io_sel,
	output ic_pkg::ic_word_t rdata
);

	localparam int LINES = 1 << `IC_INDEX_W;

	ic_pkg::ic_word_t        lines [0:LINES-1];
	ic_pkg::ic_word_t        fill_q;
	ic_pkg::ic_word_t        io_q;
	logic [`IC_INDEX_W-1:0]  idx;

	assign idx = paddr[`IC_INDEX_W+1:2];

	// fill word is kept for the cycle after mdone
	always_ff @(posedge BCLK)
	begin
		if (cupdate)
		begin
			lines[idx] <= mdata;
			fill_q     <= mdata;
		end
	end

	always_ff @(posedge BCLK)
	begin
		if (io_sel)
			io_q <= io_data;
	end

	assign rdata = aux_dat ? fill_q : (io_sel ? io_q : lines[idx]);

endmodule

// File: verilog/ic_xlat.sv
`timescale 1ns/1ns

`include "ic_cfg.svh"

module ic_xlat
(
	input  logic                BCLK,
	input  logic                BRESET,
	input  ic_pkg::ic_fetch_t   fetch,
	input  logic                tlb_wr,
	input  ic_pkg::ic_tlb_ent_t tlb_ent,
	input  logic                new_ptb,
	output ic_pkg::ic_addr_t    paddr,
	output logic                mmu_hit,
	output logic                io_space,
	output logic                prot_error
);

	localparam int SLOTS = 1 << `IC_TLB_W;

	ic_pkg::ic_tlb_ent_t     ents [0:SLOTS-1];
	logic [SLOTS-1:0]        valid;
	ic_pkg::ic_vpn_t         vpn;
	logic [`IC_TLB_W-1:0]    rd_slot;
	logic [`IC_TLB_W-1:0]    wr_slot;
	ic_pkg::ic_tlb_ent_t     ent;

	assign vpn     = fetch.va[`IC_VA_W-1:`IC_PAGE_W];
	assign rd_slot = vpn[`IC_TLB_W-1:0];
	assign wr_slot = tlb_ent.vpn[`IC_TLB_W-1:0];

	// a new page-table base drops every translation
	always_ff @(posedge BCLK or negedge BRESET)
	begin
		if (!BRESET)
			valid <= '0;
		else if (new_ptb)
			valid <= '0;
		else if (tlb_wr)
			valid[wr_slot] <= 1'b1;
	end

	always_ff @(posedge BCLK)
	begin
		if (tlb_wr)
			ents[wr_slot] <= tlb_ent;
	end

	assign ent     = ents[rd_slot];
	assign mmu_hit = valid[rd_slot] & (ent.vpn == vpn);
	assign paddr   = {ent.ppn, fetch.va[`IC_PAGE_W-1:0]};

	assign io_space   = mmu_hit & (paddr[`IC_VA_W-1 -: 4] == `IC_IO_PAGE);
	// user code may not fetch from supervisor pages
	assign prot_error = mmu_hit & fetch.user & ent.sup;

endmodule

// File: verilog/icache_top.sv
`timescale 1ns/1ns

module icache_top
(
	input  logic                BCLK,
	input  logic                BRESET,
	input  ic_pkg::ic_fetch_t   fetch,
	input  logic                tlb_wr,
	input  ic_pkg::ic_tlb_ent_t tlb_ent,
	input  logic                ptb_wr,
	input  logic                ptb_sel,
	input  logic                mdone,
	input  ic_pkg::ic_word_t    mdata,
	input  logic                io_ready,
	input  ic_pkg::ic_word_t    io_data,
	output logic                dram_acc,
	output logic                io_rd,
	output ic_pkg::ic_addr_t    maddr,
	output logic                acc_ok,
	output ic_pkg::ic_word_t    rdata,
	output logic                prot_error,
	output logic                new_ptb,
	output logic                ptb_one
);

	ic_pkg::ic_addr_t paddr;
	logic             mmu_hit;
	logic             io_space;
	logic             ca_hit;
	logic             cupdate;
	logic             aux_dat;

	assign maddr = paddr;

	ic_xlat u_xlat (
		.BCLK       (BCLK),
		.BRESET     (BRESET),
		.fetch      (fetch),
		.tlb_wr     (tlb_wr),
		.tlb_ent    (tlb_ent),
		.new_ptb    (new_ptb),
		.paddr      (paddr),
		.mmu_hit    (mmu_hit),
		.io_space   (io_space),
		.prot_error (prot_error)
	);

	icache_sm u_sm (
		.BCLK       (BCLK),
		.BRESET     (BRESET),
		.read       (fetch.read),
		.io_space   (io_space),
		.mdone      (mdone),
		.io_ready   (io_ready),
		.mmu_hit    (mmu_hit),
		.ca_hit     (ca_hit),
		.prot_error (prot_error),
		.ptb_wr     (ptb_wr),
		.ptb_sel    (ptb_sel),
		.dram_acc   (dram_acc),
		.io_rd      (io_rd),
		.acc_ok     (acc_ok),
		.cupdate    (cupdate),
		.aux_dat    (aux_dat),
		.new_ptb    (new_ptb),
		.ptb_one    (ptb_one)
	);

	// cache lines are only cleared by reset
	ic_tag_ram u_tag (
		.BCLK      (BCLK),
		.BRESET    (BRESET),
		.paddr     (paddr),
		.cupdate   (cupdate),
		.flush_all (1'b0),
		.ca_hit    (ca_hit)
	);

	ic_data_ram u_data (
		.BCLK    (BCLK),
		.paddr   (paddr),
		.cupdate (cupdate),
		.aux_dat (aux_dat),
		.mdata   (mdata),
		.io_data (io_data),
		.io_sel  (io_space),
		.rdata   (rdata)
	);

endmodule

// File: dv/icache_checker.sv
`timescale 1ns/1ns

module icache_checker
(
	input logic BCLK,
	input logic BRESET,
	input logic acc_ok,
	input logic prot_error,
	input logic ptb_wr,
	input logic new_ptb,
	input logic dram_acc,
	input logic io_rd,
	input logic mdone,
	input logic io_ready
);

	no_ok_on_prot: assert property (@(posedge BCLK) disable iff (!BRESET)
		!(acc_ok && prot_error))
		else $error("acc_ok raised together with prot_error");

	ptb_delay: assert property (@(posedge BCLK) disable iff (!BRESET)
		new_ptb == $past(ptb_wr))
		else $error("new_ptb does not follow ptb_wr");

	one_bus: assert property (@(posedge BCLK) disable iff (!BRESET)
		!(dram_acc && io_rd))
		else $error("dram_acc and io_rd high together");

	// fill data is handed over the cycle after mdone
	fill_end: assert property (@(posedge BCLK) disable iff (!BRESET)
		dram_acc && mdone |=> acc_ok)
		else $error("acc_ok missing one cycle after mdone");

	io_end: assert property (@(posedge BCLK) disable iff (!BRESET)
		io_rd && io_ready |=> acc_ok)
		else $error("acc_ok missing one cycle after io_ready");

	dram_hold: assert property (@(posedge BCLK) disable iff (!BRESET)
		dram_acc && !mdone |=> dram_acc)
		else $error("dram_acc dropped before mdone");

	io_hold: assert property (@(posedge BCLK) disable iff (!BRESET)
		io_rd && !io_ready |=> io_rd)
		else $error("io_rd dropped before io_ready");

endmodule

// File: dv/icache_tb.sv
`timescale 1ns/1ns

module icache_tb;

	localparam int TMO = 40;
	localparam int K_MISS = 0;
	localparam int K_HIT = 1;
	localparam int K_IO = 2;

	logic                BCLK;
	logic                BRESET;
	ic_pkg::ic_fetch_t   fetch;
	logic                tlb_wr;
	ic_pkg::ic_tlb_ent_t tlb_ent;
	logic                ptb_wr;
	logic                ptb_sel;
	logic                mdone;
	ic_pkg::ic_word_t    mdata;
	logic                io_ready;
	ic_pkg::ic_word_t    io_data;
	logic                dram_acc;
	logic                io_rd;
	ic_pkg::ic_addr_t    maddr;
	logic                acc_ok;
	ic_pkg::ic_word_t    rdata;
	logic                prot_error;
	logic                new_ptb;
	logic                ptb_one;

	ic_pkg::ic_word_t    exp_mem [ic_pkg::ic_addr_t];
	int                  errors;
	int                  timeouts;
	int                  d_cnt;
	int                  d_want;
	int                  i_cnt;
	int                  i_want;
	int                  cyc;
	ic_pkg::ic_addr_t    va_a;
	ic_pkg::ic_addr_t    va_b;
	ic_pkg::ic_addr_t    va_c;
	ic_pkg::ic_addr_t    pa_a;

	icache_top u_icache_top (.*);

	bind icache_top icache_checker u_checker (
		.BCLK       (BCLK),
		.BRESET     (BRESET),
		.acc_ok     (acc_ok),
		.prot_error (prot_error),
		.ptb_wr     (ptb_wr),
		.new_ptb    (new_ptb),
		.dram_acc   (dram_acc),
		.io_rd      (io_rd),
		.mdone      (mdone),
		.io_ready   (io_ready)
	);

	function automatic ic_pkg::ic_word_t dram_word(input ic_pkg::ic_addr_t a);
		return a ^ 32'hA5C3_0F1E;
	endfunction

	function automatic ic_pkg::ic_word_t io_word(input ic_pkg::ic_addr_t a);
		return ~a ^ 32'h1234_5678;
	endfunction

	task automatic report_fail(input string what);
		errors++;
		$display("ERROR: %s", what);
	endtask

	task automatic check_addr(input ic_pkg::ic_addr_t want, input ic_pkg::ic_addr_t got);
		assert (got == want)
		else
		begin
			errors++;
			$display("MISMATCH maddr: got %h expected %h", got, want);
		end
	endtask

	task automatic check_word(input ic_pkg::ic_addr_t pa, input ic_pkg::ic_word_t got);
		assert (exp_mem.exists(pa) && got == exp_mem[pa])
		else
		begin
			errors++;
			$display("MISMATCH rdata at %h: got %h expected %h", pa, got,
				exp_mem.exists(pa) ? exp_mem[pa] : 32'h0);
		end
	endtask

	task automatic load_tlb(input ic_pkg::ic_vpn_t vpn, input ic_pkg::ic_ppn_t ppn, input logic sup);
		@(posedge BCLK);
		#2;
		tlb_wr  = 1'b1;
		tlb_ent = {vpn, ppn, sup};
		@(posedge BCLK);
		#2;
		tlb_wr = 1'b0;
	endtask

	task automatic do_fetch(input ic_pkg::ic_addr_t va, input ic_pkg::ic_addr_t pa,
		input logic user, input int kind);
		int  n;
		bit  got;
		n   = 0;
		got = 0;
		@(posedge BCLK);
		#2;
		fetch = {1'b1, va, user};
		while (!got && n < TMO)
		begin
			@(negedge BCLK);
			if (kind == K_MISS && n == 1)
				assert (dram_acc) else report_fail("dram_acc did not rise after a miss");
			if (kind == K_IO && n == 1)
				assert (io_rd) else report_fail("io_rd did not rise after an I/O fetch");
			if (kind != K_MISS)
				assert (!dram_acc) else report_fail("unexpected DRAM access");
			if (kind != K_IO)
				assert (!io_rd) else report_fail("unexpected I/O access");
			if (acc_ok)
			begin
				got = 1;
				if (kind == K_HIT)
					assert (n == 0) else report_fail("cache hit was not served at once");
				check_addr(pa, maddr);
				check_word(pa, rdata);
			end
			n++;
		end
		if (!got)
		begin
			timeouts++;
			$display("timeout waiting for acc_ok at va %h", va);
		end
		@(posedge BCLK);
		#2;
		fetch.read = 1'b0;
	endtask

	initial
	begin
		BCLK = 1'b0;
		forever #10 BCLK = ~BCLK;
	end

	// DRAM answers after 1 to 4 cycles
	initial
	begin
		mdone = 1'b0;
		mdata = '0;
		d_cnt = 0;
		forever
		begin
			@(posedge BCLK);
			#2;
			if (mdone)
			begin
				mdone = 1'b0;
				d_cnt = 0;
			end
			else if (dram_acc)
			begin
				if (d_cnt == 0)
					d_want = $urandom_range(1, 4);
				d_cnt++;
				if (d_cnt >= d_want)
				begin
					mdone          = 1'b1;
					mdata          = dram_word(maddr);
					exp_mem[maddr] = mdata;
				end
			end
		end
	end

	initial
	begin
		io_ready = 1'b0;
		io_data  = '0;
		i_cnt    = 0;
		forever
		begin
			@(posedge BCLK);
			#2;
			if (io_ready)
			begin
				io_ready = 1'b0;
				i_cnt    = 0;
			end
			else if (io_rd)
			begin
				if (i_cnt == 0)
					i_want = $urandom_range(1, 4);
				i_cnt++;
				if (i_cnt >= i_want)
				begin
					io_ready       = 1'b1;
					io_data        = io_word(maddr);
					exp_mem[maddr] = io_data;
				end
			end
		end
	end

	initial
	begin
		#200000;
		$display("simulation time limit reached");
		$display("Test failures found");
		$finish;
	end

	initial
	begin
		void'($urandom(74));
		errors   = 0;
		timeouts = 0;
		BRESET   = 1'b0;
		fetch    = '0;
		tlb_wr   = 1'b0;
		tlb_ent  = '0;
		ptb_wr   = 1'b0;
		ptb_sel  = 1'b0;
		repeat (3) @(posedge BCLK);
		#2;
		BRESET = 1'b1;
		@(negedge BCLK);
		assert (!dram_acc && !io_rd && !acc_ok && !new_ptb && !ptb_one)
		else report_fail("control outputs not low after reset");

		load_tlb(22'h00010, 22'h00123, 1'b0);
		load_tlb(22'h00021, {4'hF, 18'h00ABC}, 1'b0);
		load_tlb(22'h00032, 22'h00456, 1'b1);

		va_a = {22'h00010, 10'($urandom & 32'h3FC)};
		va_c = {22'h00032, va_a[9:0] ^ 10'h004};
		va_b = {22'h00021, 10'($urandom & 32'h3FC)};
		pa_a = {22'h00123, va_a[9:0]};
		do_fetch(va_a, pa_a, 1'b1, K_MISS);
		do_fetch(va_a, pa_a, 1'b1, K_HIT);
		do_fetch(va_b, {4'hF, 18'h00ABC, va_b[9:0]}, 1'b1, K_IO);
		do_fetch({22'h00021, 10'h010}, {4'hF, 18'h00ABC, 10'h010}, 1'b0, K_IO);
		do_fetch({22'h00021, 10'h010}, {4'hF, 18'h00ABC, 10'h010}, 1'b0, K_IO);

		// user fetch from a supervisor page must start nothing
		@(posedge BCLK);
		#2;
		fetch = {1'b1, va_c, 1'b1};
		repeat (8)
		begin
			@(negedge BCLK);
			assert (prot_error && !acc_ok && !dram_acc && !io_rd)
			else report_fail("protected fetch was not blocked");
		end
		@(posedge BCLK);
		#2;
		fetch.read = 1'b0;
		do_fetch(va_c, {22'h00456, va_c[9:0]}, 1'b0, K_MISS);

		@(posedge BCLK);
		#2;
		ptb_wr  = 1'b1;
		ptb_sel = 1'b1;
		@(posedge BCLK);
		#2;
		ptb_wr = 1'b0;
		@(negedge BCLK);
		assert (new_ptb && ptb_one) else report_fail("page-table base write not seen");
		@(posedge BCLK);
		#2;
		fetch = {1'b1, va_a, 1'b1};
		repeat (8)
		begin
			@(negedge BCLK);
			assert (!acc_ok && !dram_acc) else report_fail("fetch went on without a translation");
		end
		load_tlb(22'h00010, 22'h00123, 1'b0);
		cyc = 0;
		@(negedge BCLK);
		while (!acc_ok && cyc < TMO)
		begin
			@(negedge BCLK);
			cyc++;
		end
		if (acc_ok)
		begin
			check_addr(pa_a, maddr);
			check_word(pa_a, rdata);
		end
		else
		begin
			timeouts++;
			$display("timeout waiting for acc_ok after translation reload");
		end
		@(posedge BCLK);
		#2;
		fetch.read = 1'b0;

		// a second base write with the other select value
		@(posedge BCLK);
		#2;
		ptb_wr  = 1'b1;
		ptb_sel = 1'b0;
		@(posedge BCLK);
		#2;
		ptb_wr = 1'b0;
		@(negedge BCLK);
		assert (new_ptb && !ptb_one) else report_fail("ptb_one did not take ptb_sel");
		repeat (4) @(posedge BCLK);

		$display("errors=%0d timeouts=%0d", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// File: verilog.f
+incdir+verilog
verilog/ic_pkg.sv
verilog/icache_sm.sv
verilog/ic_tag_ram.sv
verilog/ic_data_ram.sv
verilog/ic_xlat.sv
verilog/icache_top.sv
dv/icache_checker.sv
dv/icache_tb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = icache_tb
FILELIST = verilog.f
OBJDIR   = obj_dir
BIN      = $(OBJDIR)/V$(TOP)
LOG      = sim.log
SRCS     = $(wildcard verilog/*.sv verilog/*.svh dv/*.sv)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
